//--- list.f
verilog/icache_pkg.sv
verilog/fill_if.sv
verilog/line_store.sv
verilog/icache.sv
verilog/prefetch_unit.sv
verilog/icache_top.sv
bench/imem_model.sv
bench/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/icache_tb.sv
`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PREFETCH_DISTANCE = 4;
    localparam int MEM_LATENCY       = 12;
    localparam int SEED              = 16;
    localparam int CLOCK_PERIOD      = 8;
    localparam int RESET_CYCLES      = 16;
    localparam int RUN_CYCLES        = 20000;
    localparam int FILL_WINDOW       = 60;

    typedef logic [15-icache_pkg::OFFSET_BITS:0] line_addr_t;

    logic                     clock;
    logic                     reset;
    icache_pkg::addr_t        fetch_addr;
    icache_pkg::br_task_t     br_task;
    icache_pkg::mem_tag_t     mem_transaction_tag;
    icache_pkg::block_t       mem_data;
    icache_pkg::mem_tag_t     mem_data_tag;
    icache_pkg::mem_command_t mem_command;
    icache_pkg::addr_t        mem_addr;
    icache_pkg::addr_t        resp_addr;
    icache_pkg::block_t [icache_pkg::READ_LINES-1:0] icache_data;
    logic               [icache_pkg::READ_LINES-1:0] icache_valid;
    logic               [icache_pkg::READ_LINES-1:0] icache_alloc;

    // reference copy of the line state
    logic [icache_pkg::ICACHE_LINES-1:0] model_valid;
    logic [icache_pkg::ICACHE_LINES-1:0] model_alloc;
    icache_pkg::cache_tag_t              model_tag [icache_pkg::ICACHE_LINES];
    // tags whose response still counts
    logic [icache_pkg::MEM_TAGS-1:0]     live_tag;

    int errors = 0;
    int checks = 0;
    int fills = 0;
    int late_drops = 0;
    int held = 0;
    int reset_edges = 0;
    logic after_reset = 1'b0;
    logic squash_seen = 1'b0;
    logic refused_seen = 1'b0;
    icache_pkg::addr_t refused_addr = '0;
    icache_pkg::addr_t last_fetch = '0;

    icache_top #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE)
    ) i_dut (
        .clock               (clock),
        .reset               (reset),
        .fetch_addr          (fetch_addr),
        .br_task             (br_task),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .icache_data         (icache_data),
        .icache_valid        (icache_valid),
        .icache_alloc        (icache_alloc)
    );

    imem_model #(
        .LATENCY (MEM_LATENCY)
    ) i_mem (
        .clock               (clock),
        .reset               (reset),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .resp_addr           (resp_addr)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        $display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    // memory content rule: address low, inverse high
    function automatic icache_pkg::block_t expected_block(icache_pkg::addr_t a);
        logic [31:0] low;
        low = {16'h0000, a};
        return {~low, low};
    endfunction

    function automatic icache_pkg::addr_t next_fetch(icache_pkg::addr_t current);
        int unsigned pick;
        pick = $urandom_range(2);
        if (pick == 0) begin
            return current + 16'd8;
        end else if (pick == 1) begin
            return current + 16'd16;
        end
        return icache_pkg::addr_t'($urandom);
    endfunction

    // now and then a long hold so the window fills up
    function automatic int unsigned hold_length();
        if ($urandom_range(7) == 0) begin
            return 80 + $urandom_range(40);
        end
        return 1 + $urandom_range(39);
    endfunction

    task automatic clear_model();
        model_valid  = '0;
        model_alloc  = '0;
        live_tag     = '0;
        held         = 0;
        squash_seen  = 1'b0;
        refused_seen = 1'b0;
        last_fetch   = fetch_addr;
        for (int i = 0; i < icache_pkg::ICACHE_LINES; i++) begin
            model_tag[i] = '0;
        end
    endtask

    // MEM_LOAD must stay in the window and target a missing line
    task automatic check_request(input line_addr_t fetch_line);
        line_addr_t              req_line;
        icache_pkg::line_index_t idx;
        logic                    repeated;
        req_line = mem_addr[15:icache_pkg::OFFSET_BITS];
        idx      = req_line[icache_pkg::LINE_BITS-1:0];
        repeated = refused_seen && (refused_addr == mem_addr);
        if (mem_addr[icache_pkg::OFFSET_BITS-1:0] != '0) begin
            report_failure($sformatf("request address %h is not block aligned", mem_addr));
        end
        if (line_addr_t'(req_line - fetch_line) >= PREFETCH_DISTANCE) begin
            report_failure($sformatf("request %h outside the prefetch window", mem_addr));
        end
        if (!repeated && (model_alloc[idx] || (model_valid[idx] &&
                model_tag[idx] == req_line[15-icache_pkg::OFFSET_BITS:icache_pkg::LINE_BITS]))) begin
            report_failure($sformatf("request %h for a present or allocated line", mem_addr));
        end
    endtask

    // state change at this edge, from the events seen in the cycle
    task automatic update_model();
        icache_pkg::line_index_t idx;
        refused_seen = (mem_command == icache_pkg::MEM_LOAD) && (mem_transaction_tag == '0);
        refused_addr = mem_addr;
        squash_seen  = (br_task == icache_pkg::SQUASH);
        if (squash_seen) begin
            // in-flight fills forgotten, late responses discarded
            model_alloc = '0;
            live_tag    = '0;
        end else begin
            if (mem_data_tag != '0 && live_tag[mem_data_tag]) begin
                idx = resp_addr[icache_pkg::OFFSET_BITS +: icache_pkg::LINE_BITS];
                model_valid[idx]       = 1'b1;
                model_tag[idx]         = resp_addr[15:icache_pkg::OFFSET_BITS+icache_pkg::LINE_BITS];
                model_alloc[idx]       = 1'b0;
                live_tag[mem_data_tag] = 1'b0;
                fills++;
            end else if (mem_data_tag != '0) begin
                late_drops++;
            end
            if (mem_command == icache_pkg::MEM_LOAD && mem_transaction_tag != '0) begin
                idx = mem_addr[icache_pkg::OFFSET_BITS +: icache_pkg::LINE_BITS];
                model_alloc[idx]              = 1'b1;
                live_tag[mem_transaction_tag] = 1'b1;
            end
        end
        last_fetch = fetch_addr;
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, stimulus, watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        int unsigned hold;
        void'($urandom(SEED));
        reset      = 1'b1;
        fetch_addr = '0;
        br_task    = icache_pkg::BR_NONE;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        hold  = 0;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(negedge clock);
            if (hold == 0) begin
                fetch_addr = next_fetch(fetch_addr);
                hold       = hold_length();
            end
            hold--;
            br_task = ($urandom_range(99) < 3) ? icache_pkg::SQUASH : icache_pkg::BR_NONE;
        end
        // one more edge so the last cycle gets checked
        @(negedge clock);
        if (fills == 0) begin
            report_failure("no block was ever filled");
        end
        $display("%0d slot checks, %0d fills, %0d late responses dropped, %0d errors",
                 checks, fills, late_drops, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #((RUN_CYCLES + RESET_CYCLES + 200) * CLOCK_PERIOD);
        $display("watchdog expired before the stimulus finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // checker, samples pre-edge values
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        line_addr_t              fetch_line;
        line_addr_t              slot_line;
        icache_pkg::line_index_t idx;
        logic                    exp_valid;
        logic                    writing;
        icache_pkg::block_t      exp_data;
        fetch_line = fetch_addr[15:icache_pkg::OFFSET_BITS];
        if (reset) begin
            clear_model();
            reset_edges++;
            // line state cleared from the second reset edge
            if (reset_edges > 1 && mem_command !== icache_pkg::MEM_NONE) begin
                report_value("mem_command", icache_pkg::MEM_NONE, mem_command);
            end
            if (reset_edges > 1 && icache_valid !== '0) begin
                report_value("icache_valid", '0, icache_valid);
            end
            after_reset = 1'b1;
        end else begin
            if (after_reset && mem_command !== icache_pkg::MEM_NONE) begin
                report_value("mem_command", icache_pkg::MEM_NONE, mem_command);
            end
            if (after_reset && icache_valid !== '0) begin
                report_value("icache_valid", '0, icache_valid);
            end
            after_reset = 1'b0;
            if (fetch_addr == last_fetch && !squash_seen) begin
                held++;
            end else begin
                held = 0;
            end
            // a live response is bypassed onto the read ports
            writing = (mem_data_tag != '0) && live_tag[mem_data_tag] &&
                      (br_task != icache_pkg::SQUASH);
            for (int i = 0; i < icache_pkg::READ_LINES; i++) begin
                slot_line = fetch_line + line_addr_t'(i);
                idx       = slot_line[icache_pkg::LINE_BITS-1:0];
                exp_valid = model_valid[idx] &&
                    (model_tag[idx] == slot_line[15-icache_pkg::OFFSET_BITS:icache_pkg::LINE_BITS]);
                checks++;
                if (icache_valid[i] !== exp_valid) begin
                    report_value($sformatf("icache_valid[%0d]", i), exp_valid, icache_valid[i]);
                end
                if (icache_alloc[i] !== model_alloc[idx]) begin
                    report_value($sformatf("icache_alloc[%0d]", i), model_alloc[idx],
                                 icache_alloc[i]);
                end
                if (icache_valid[i] === 1'b1) begin
                    if (writing && resp_addr[icache_pkg::OFFSET_BITS +: icache_pkg::LINE_BITS] == idx) begin
                        exp_data = expected_block(resp_addr);
                    end else begin
                        exp_data = expected_block({slot_line, {icache_pkg::OFFSET_BITS{1'b0}}});
                    end
                    if (icache_data[i] !== exp_data) begin
                        report_value($sformatf("icache_data[%0d]", i), exp_data, icache_data[i]);
                    end
                end
            end
            if (squash_seen && icache_alloc !== '0) begin
                report_failure("alloc bits still set in the cycle after a squash");
            end
            if (held >= FILL_WINDOW && icache_valid !== 2'b11) begin
                report_failure($sformatf("fetch address %h not filled after %0d held cycles",
                                         fetch_addr, held));
            end
            if (mem_command == icache_pkg::MEM_LOAD) begin
                check_request(fetch_line);
            end
            update_model();
        end
    end

endmodule

`default_nettype wire

//--- bench/imem_model.sv
`default_nettype none

module imem_model #(
    parameter int LATENCY = 12
) (
    input  logic                     clock,
    input  logic                     reset,
    input  icache_pkg::mem_command_t mem_command,
    input  icache_pkg::addr_t        mem_addr,
    output icache_pkg::mem_tag_t     mem_transaction_tag,
    output icache_pkg::block_t       mem_data,
    output icache_pkg::mem_tag_t     mem_data_tag,
    // address of the block on mem_data, for the checker
    output icache_pkg::addr_t        resp_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    // tags in flight, bit 0 never used
    logic [icache_pkg::MEM_TAGS-1:0] busy = '0;
    // tag offered this cycle, 0 refuses
    icache_pkg::mem_tag_t offer_tag = '0;
    icache_pkg::mem_tag_t resp_tag = '0;
    icache_pkg::block_t   resp_block = '0;
    icache_pkg::addr_t    resp_address = '0;
    int unsigned          cycle = 0;

    // fixed latency, so responses leave in issue order
    icache_pkg::mem_tag_t pend_tag  [$];
    icache_pkg::addr_t    pend_addr [$];
    int unsigned          pend_due  [$];

    // address in the low half, its inverse above
    function automatic icache_pkg::block_t block_pattern(icache_pkg::addr_t a);
        logic [31:0] low;
        low = {16'h0000, a};
        return {~low, low};
    endfunction

    // accept answers in the same cycle as the request
    assign mem_transaction_tag = (mem_command == icache_pkg::MEM_LOAD) ? offer_tag : '0;
    assign mem_data_tag        = resp_tag;
    assign mem_data            = resp_block;
    assign resp_addr           = resp_address;

    //////////////////////////////////////////////////////////////////////
    // drive side, falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        int unsigned start;
        int unsigned t;
        resp_tag     = '0;
        resp_block   = '0;
        resp_address = '0;
        offer_tag    = '0;
        if (!reset) begin
            // oldest request due now
            if (pend_tag.size() > 0 && pend_due[0] <= cycle) begin
                resp_tag     = pend_tag.pop_front();
                resp_address = pend_addr.pop_front();
                void'(pend_due.pop_front());
                resp_block   = block_pattern(resp_address);
            end
            // three in four, random free tag from 1 up
            if ($urandom_range(3) != 0) begin
                start = $urandom_range(icache_pkg::MEM_TAGS - 2);
                for (int k = 0; k < icache_pkg::MEM_TAGS - 1; k++) begin
                    t = 1 + (start + k) % (icache_pkg::MEM_TAGS - 1);
                    if (!busy[t] && offer_tag == '0) begin
                        offer_tag = icache_pkg::mem_tag_t'(t);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sample side, rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            busy  = '0;
            cycle = 0;
            pend_tag.delete();
            pend_addr.delete();
            pend_due.delete();
        end else begin
            // tag free again once its block went out
            if (resp_tag != '0) begin
                busy[resp_tag] = 1'b0;
            end
            if (mem_command == icache_pkg::MEM_LOAD && mem_transaction_tag != '0) begin
                busy[mem_transaction_tag] = 1'b1;
                pend_tag.push_back(mem_transaction_tag);
                pend_addr.push_back(mem_addr);
                pend_due.push_back(cycle + LATENCY);
            end
            cycle++;
        end
    end

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
`default_nettype none

module icache_top #(
    parameter int PREFETCH_DISTANCE = 4
) (
    input  logic                                             clock,
    input  logic                                             reset,
    input  icache_pkg::addr_t                                fetch_addr,
    input  icache_pkg::br_task_t                             br_task,
    // memory side
    input  icache_pkg::mem_tag_t                             mem_transaction_tag,
    input  icache_pkg::block_t                               mem_data,
    input  icache_pkg::mem_tag_t                             mem_data_tag,
    output icache_pkg::mem_command_t                         mem_command,
    output icache_pkg::addr_t                                mem_addr,
    // fetch side
    output icache_pkg::block_t [icache_pkg::READ_LINES-1:0]  icache_data,
    output logic               [icache_pkg::READ_LINES-1:0]  icache_valid,
    output logic               [icache_pkg::READ_LINES-1:0]  icache_alloc
);

    //////////////////////////////////////////////////////////////////////
    // prefetcher to cache link
    //////////////////////////////////////////////////////////////////////

    fill_if fill ();

    icache i_icache (
        .clock        (clock),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .br_task      (br_task),
        .fill         (fill.cache),
        .icache_data  (icache_data),
        .icache_valid (icache_valid),
        .icache_alloc (icache_alloc)
    );

    // owns the memory port
    prefetch_unit #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE)
    ) i_prefetch (
        .clock               (clock),
        .reset               (reset),
        .fetch_addr          (fetch_addr),
        .br_task             (br_task),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .fill                (fill.prefetch),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr)
    );

endmodule

`default_nettype wire

//--- verilog/prefetch_unit.sv
`default_nettype none

module prefetch_unit #(
    parameter int PREFETCH_DISTANCE = 4
) (
    input  logic                     clock,
    input  logic                     reset,
    input  icache_pkg::addr_t        fetch_addr,
    input  icache_pkg::br_task_t     br_task,
    input  icache_pkg::mem_tag_t     mem_transaction_tag,
    input  icache_pkg::block_t       mem_data,
    input  icache_pkg::mem_tag_t     mem_data_tag,
    fill_if.prefetch                 fill,
    output icache_pkg::mem_command_t mem_command,
    output icache_pkg::addr_t        mem_addr
);

    typedef logic [$bits(icache_pkg::addr_t)-icache_pkg::OFFSET_BITS-1:0] line_addr_t;

    line_addr_t fetch_line;
    line_addr_t prev_line;
    line_addr_t probe_line;

    // walk cursor, offset from the fetch line
    icache_pkg::line_index_t cursor;
    icache_pkg::line_index_t cur;
    icache_pkg::line_index_t cursor_next;

    logic walk_en;
    logic line_changed;
    logic squash;
    logic in_table;
    logic need;
    logic accepted;
    logic advance;
    logic resp_hit;

    // outstanding transactions, indexed by memory tag
    logic [icache_pkg::MEM_TAGS-1:0] entry_valid;
    icache_pkg::addr_t               entry_addr [icache_pkg::MEM_TAGS];

    assign fetch_line   = fetch_addr[$bits(icache_pkg::addr_t)-1:icache_pkg::OFFSET_BITS];
    assign line_changed = (fetch_line != prev_line);
    assign squash       = (br_task == icache_pkg::SQUASH);

    //////////////////////////////////////////////////////////////////////
    // window walk
    //////////////////////////////////////////////////////////////////////

    // new fetch line restarts at offset 0 right away
    assign cur        = line_changed ? '0 : cursor;
    assign probe_line = fetch_line + line_addr_t'(cur);
    assign mem_addr   = {probe_line, {icache_pkg::OFFSET_BITS{1'b0}}};

    // already being fetched under some tag?
    always_comb begin
        in_table = 1'b0;
        for (int t = 0; t < icache_pkg::MEM_TAGS; t++) begin
            if (entry_valid[t] && (entry_addr[t] == mem_addr)) begin
                in_table = 1'b1;
            end
        end
    end

    // missing and not on its way
    assign need = walk_en && !squash && !fill.probe_hit && !fill.probe_alloc && !in_table;

    assign mem_command = need ? icache_pkg::MEM_LOAD : icache_pkg::MEM_NONE;
    assign accepted    = need && (mem_transaction_tag != '0);

    // a refused request holds the cursor
    assign advance = !need || accepted;

    always_comb begin
        if (!advance) begin
            cursor_next = cur;
        end else if (cur == icache_pkg::line_index_t'(PREFETCH_DISTANCE - 1)) begin
            cursor_next = '0;
        end else begin
            cursor_next = cur + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fill side
    //////////////////////////////////////////////////////////////////////

    // tag 0 never indexes a live entry
    assign resp_hit = (mem_data_tag != '0) && entry_valid[mem_data_tag];

    assign fill.probe_addr = mem_addr;
    assign fill.alloc_en   = accepted;
    assign fill.alloc_addr = mem_addr;
    assign fill.write_en   = resp_hit;
    assign fill.write_addr = entry_addr[mem_data_tag];
    assign fill.write_data = mem_data;

    //////////////////////////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            walk_en     <= 1'b0;
            cursor      <= '0;
            prev_line   <= '0;
            entry_valid <= '0;
        end else begin
            // walk starts one cycle out of reset
            walk_en   <= 1'b1;
            cursor    <= cursor_next;
            prev_line <= fetch_line;
            if (squash) begin
                // late responses then miss the table
                entry_valid <= '0;
            end else begin
                if (resp_hit) begin
                    entry_valid[mem_data_tag] <= 1'b0;
                end
                if (accepted) begin
                    entry_valid[mem_transaction_tag] <= 1'b1;
                end
            end
        end
    end

    // address payload, meaningful only while the entry is valid
    always_ff @(posedge clock) begin
        if (accepted) begin
            entry_addr[mem_transaction_tag] <= mem_addr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // memory must not reuse a tag still in flight
    accept_tag_free: assert property (
        @(posedge clock) disable iff (reset)
        (mem_command == icache_pkg::MEM_LOAD && mem_transaction_tag != '0)
            |-> !entry_valid[mem_transaction_tag]
    ) else $error("prefetch_unit: tag %0d handed out while live", mem_transaction_tag);

endmodule

`default_nettype wire

//--- verilog/icache.sv
`default_nettype none

module icache (
    input  logic                                             clock,
    input  logic                                             reset,
    input  icache_pkg::addr_t                                fetch_addr,
    input  icache_pkg::br_task_t                             br_task,
    fill_if.cache                                            fill,
    output icache_pkg::block_t [icache_pkg::READ_LINES-1:0]  icache_data,
    output logic               [icache_pkg::READ_LINES-1:0]  icache_valid,
    output logic               [icache_pkg::READ_LINES-1:0]  icache_alloc
);

    // line address is the byte address without its offset
    typedef logic [$bits(icache_pkg::addr_t)-icache_pkg::OFFSET_BITS-1:0] line_addr_t;

    icache_pkg::line_state_t [icache_pkg::ICACHE_LINES-1:0] lines;

    line_addr_t                                          fetch_line;
    line_addr_t              [icache_pkg::READ_LINES-1:0] slot_line;
    icache_pkg::line_index_t [icache_pkg::READ_LINES-1:0] slot_index;
    icache_pkg::cache_tag_t  [icache_pkg::READ_LINES-1:0] slot_tag;

    line_addr_t              probe_line;
    icache_pkg::line_index_t probe_index;
    icache_pkg::cache_tag_t  probe_tag;

    line_addr_t              write_line;
    icache_pkg::line_index_t write_index;
    icache_pkg::cache_tag_t  write_tag;

    icache_pkg::line_index_t alloc_index;

    logic squash;
    logic store_we;

    //////////////////////////////////////////////////////////////////////
    // address split
    //////////////////////////////////////////////////////////////////////

    assign fetch_line = fetch_addr[$bits(icache_pkg::addr_t)-1:icache_pkg::OFFSET_BITS];
    assign probe_line = fill.probe_addr[$bits(icache_pkg::addr_t)-1:icache_pkg::OFFSET_BITS];
    assign write_line = fill.write_addr[$bits(icache_pkg::addr_t)-1:icache_pkg::OFFSET_BITS];

    assign {probe_tag, probe_index} = probe_line;
    assign {write_tag, write_index} = write_line;
    // allocate marks only the index, the tag comes with the later write
    assign alloc_index = fill.alloc_addr[icache_pkg::OFFSET_BITS +: icache_pkg::LINE_BITS];

    assign squash = (br_task == icache_pkg::SQUASH);

    // writes during a squash are dropped
    assign store_we = fill.write_en && !squash;

    //////////////////////////////////////////////////////////////////////
    // two-line lookup
    //////////////////////////////////////////////////////////////////////

    // slot i looks at fetch line + i with the tag carrying on index wrap
    always_comb begin
        for (int i = 0; i < icache_pkg::READ_LINES; i++) begin
            slot_line[i] = fetch_line + line_addr_t'(i);
            {slot_tag[i], slot_index[i]} = slot_line[i];
            icache_valid[i] = lines[slot_index[i]].valid &&
                              (lines[slot_index[i]].tag == slot_tag[i]);
            icache_alloc[i] = lines[slot_index[i]].alloc;
        end
    end

    line_store #(
        .READ_PORTS (icache_pkg::READ_LINES),
        .DEPTH      (icache_pkg::ICACHE_LINES)
    ) i_store (
        .clock (clock),
        .reset (reset),
        .we    (store_we),
        .waddr (write_index),
        .wdata (fill.write_data),
        .raddr (slot_index),
        .rdata (icache_data)
    );

    //////////////////////////////////////////////////////////////////////
    // probe port
    //////////////////////////////////////////////////////////////////////

    assign fill.probe_hit   = lines[probe_index].valid && (lines[probe_index].tag == probe_tag);
    assign fill.probe_alloc = lines[probe_index].alloc;

    //////////////////////////////////////////////////////////////////////
    // line state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            lines <= '0;
        end else if (squash) begin
            // in-flight fills are abandoned
            for (int i = 0; i < icache_pkg::ICACHE_LINES; i++) begin
                lines[i].alloc <= 1'b0;
            end
        end else begin
            // returned block makes the line present
            if (fill.write_en) begin
                lines[write_index].valid <= 1'b1;
                lines[write_index].tag   <= write_tag;
                lines[write_index].alloc <= 1'b0;
            end
            // request taken by memory
            if (fill.alloc_en) begin
                lines[alloc_index].alloc <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // prefetcher never fills and allocates one index at once
    no_alloc_write_clash: assert property (
        @(posedge clock) disable iff (reset)
        (fill.alloc_en && fill.write_en) |-> (alloc_index != write_index)
    ) else $error("icache: allocate and write both hit index %0d", alloc_index);

endmodule

`default_nettype wire

//--- verilog/line_store.sv
`default_nettype none

module line_store #(
    parameter int READ_PORTS = 2,
    parameter int DEPTH      = icache_pkg::ICACHE_LINES
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     we,
    input  icache_pkg::line_index_t                  waddr,
    input  icache_pkg::block_t                       wdata,
    input  icache_pkg::line_index_t [READ_PORTS-1:0] raddr,
    output icache_pkg::block_t      [READ_PORTS-1:0] rdata
);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    icache_pkg::block_t mem [DEPTH];

    // one write per cycle
    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////

    // combinational reads, same-cycle write forwarded
    always_comb begin
        for (int i = 0; i < READ_PORTS; i++) begin
            if (we && (waddr == raddr[i])) begin
                rdata[i] = wdata;
            end else begin
                rdata[i] = mem[raddr[i]];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // write index must land inside the array
    waddr_in_range: assert property (
        @(posedge clock) disable iff (reset)
        we |-> (int'(waddr) < DEPTH)
    ) else $error("line_store: write index %0d outside depth %0d", waddr, DEPTH);

endmodule

`default_nettype wire

//--- verilog/fill_if.sv
`default_nettype none

interface fill_if;

    // probe of one window line
    icache_pkg::addr_t  probe_addr;
    logic               probe_hit;
    logic               probe_alloc;

    // request accepted by memory
    logic               alloc_en;
    icache_pkg::addr_t  alloc_addr;

    // returned block
    logic               write_en;
    icache_pkg::addr_t  write_addr;
    icache_pkg::block_t write_data;

    modport cache (
        input  probe_addr, alloc_en, alloc_addr, write_en, write_addr, write_data,
        output probe_hit, probe_alloc
    );

    modport prefetch (
        output probe_addr, alloc_en, alloc_addr, write_en, write_addr, write_data,
        input  probe_hit, probe_alloc
    );

endinterface

`default_nettype wire

//--- verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ICACHE_LINES = 32;
    localparam int LINE_BITS    = 5;
    localparam int OFFSET_BITS  = 3;
    // fetch reads this many consecutive lines per cycle
    localparam int READ_LINES   = 2;
    // tag 0 is the sentinel, so only 15 are usable
    localparam int MEM_TAGS     = 16;

    //////////////////////////////////////////////////////////////////////
    // basic types
    //////////////////////////////////////////////////////////////////////

    // byte address, split as tag | index | offset
    typedef logic [15:0] addr_t;
    typedef logic [63:0] block_t;
    typedef logic [LINE_BITS-1:0] line_index_t;
    typedef logic [7:0] cache_tag_t;
    // memory transaction tag, not a cache tag
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        MEM_NONE = 2'h0,
        MEM_LOAD = 2'h1
    } mem_command_t;

    typedef enum logic [1:0] {
        BR_NONE = 2'h0,
        SQUASH  = 2'h1
    } br_task_t;

    // per-line bookkeeping
    typedef struct packed {
        logic       valid;
        cache_tag_t tag;
        // fill in flight for this line
        logic       alloc;
    } line_state_t;

endpackage

`default_nettype wire
